//--- common/feed_if.sv
// job-phase controls from the controller to feeder, array and drain
// one driver modport and one reader modport per datapath block
`timescale 1ns/100ps
`default_nettype none

interface feed_if #(
    parameter int N = sa_pkg::DEF_N
);

    // step spans 0 .. 3N-3
    localparam int STEP_W = $clog2(3*N-2);

    // one-cycle pulse, zeroes every accumulator
    logic acc_clr;
    // high while skewed operands are issued
    logic feed_en;
    // skew position, only meaningful with feed_en
    logic [STEP_W-1:0] step;
    // one-cycle pulse, results are stable here
    logic capture;

    modport ctrl (output acc_clr, output feed_en, output step, output capture);
    modport feeder (input feed_en, input step);
    modport array (input acc_clr);
    modport drain (input capture);

endinterface

`default_nettype wire

//--- common/sa_pkg.sv
// shared types and default constants for the systolic matrix multiplier
// modules take defaults by scoped name and body items by wildcard import
`default_nettype none

package sa_pkg;

    // target matrix of a host operand write
    typedef enum logic {
        MAT_A = 1'b0,
        MAT_B = 1'b1
    } mat_sel_t;

    // default matrix dimension
    localparam int DEF_N = 3;

    // default element format, Q(WIDTH-FRAC).FRAC signed
    localparam int DEF_WIDTH = 16;
    localparam int DEF_FRAC = 8;

    // headroom bits above the full product width in the accumulate adder
    localparam int ACC_GUARD = 4;

endpackage

`default_nettype wire

//--- list.f
common/sa_pkg.sv
common/feed_if.sv
pe_array/saturate.sv
pe_array/pe.sv
pe_array/pe_array.sv
src/sa_ctrl.sv
src/operand_feeder.sv
src/result_drain.sv
src/sa_top.sv
tests/sa_chk.sv
tests/sa_tb.sv

//--- pe_array/pe.sv
// systolic processing element: signed fixed-point multiply-accumulate
// with per-step truncation and saturation, operands forwarded east and south
`timescale 1ns/100ps
`default_nettype none

module pe #(
    parameter int WIDTH = sa_pkg::DEF_WIDTH,
    parameter int FRAC = sa_pkg::DEF_FRAC
) (
    input  logic clk,
    input  logic rst_n,
    input  logic acc_clr,
    input  logic signed [WIDTH-1:0] in_west,
    input  logic signed [WIDTH-1:0] in_north,
    output logic signed [WIDTH-1:0] out_east,
    output logic signed [WIDTH-1:0] out_south,
    output logic signed [WIDTH-1:0] result
);

    import sa_pkg::*;

    // full product scale, then headroom for the add
    localparam int MULT_W = 2*WIDTH;
    localparam int MULT_FRAC = 2*FRAC;
    localparam int ACC_W = MULT_W + ACC_GUARD;

    logic signed [MULT_W-1:0] prod;
    logic signed [ACC_W-1:0] prod_ext;
    logic signed [ACC_W-1:0] acc_aligned;
    logic signed [ACC_W-1:0] sum;
    logic signed [WIDTH-1:0] acc_nxt;

    assign prod = in_west * in_north;
    assign prod_ext = ACC_W'(prod);
    // held result moved up to product scale, low bits zero
    assign acc_aligned = ACC_W'(result) <<< (MULT_FRAC - FRAC);
    assign sum = prod_ext + acc_aligned;

    // back to element scale, floor then clamp
    saturate #(
        .IN_WIDTH(ACC_W),
        .OUT_WIDTH(WIDTH),
        .FRAC_IN(MULT_FRAC),
        .FRAC_OUT(FRAC)
    ) u_sat (
        .in(sum),
        .out(acc_nxt)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_east <= '0;
            out_south <= '0;
            result <= '0;
        end else begin
            out_east <= in_west;
            out_south <= in_north;
            // clear wins over accumulate
            result <= acc_clr ? '0 : acc_nxt;
        end
    end

endmodule

`default_nettype wire

//--- pe_array/pe_array.sv
// N x N output-stationary grid of PEs
// A enters on the west edge per row, B on the north edge per column
`timescale 1ns/100ps
`default_nettype none

module pe_array #(
    parameter int N = sa_pkg::DEF_N,
    parameter int WIDTH = sa_pkg::DEF_WIDTH,
    parameter int FRAC = sa_pkg::DEF_FRAC
) (
    input  logic clk,
    input  logic rst_n,
    input  logic [N-1:0][WIDTH-1:0] west_data,
    input  logic [N-1:0][WIDTH-1:0] north_data,
    feed_if.array fif,
    output logic [N-1:0][N-1:0][WIDTH-1:0] results
);

    // horizontal links, column j feeds PE(i,j), column N is the east edge
    logic [N-1:0][N:0][WIDTH-1:0] h_link;
    // vertical links, row i feeds PE(i,j), row N is the south edge
    logic [N:0][N-1:0][WIDTH-1:0] v_link;

    genvar i, j;
    generate
        for (i = 0; i < N; i++) begin : g_edge
            // edge vectors from the feeder
            assign h_link[i][0] = west_data[i];
            assign v_link[0][i] = north_data[i];
        end

        for (i = 0; i < N; i++) begin : g_row
            for (j = 0; j < N; j++) begin : g_col
                pe #(
                    .WIDTH(WIDTH),
                    .FRAC(FRAC)
                ) u_pe (
                    .clk(clk),
                    .rst_n(rst_n),
                    .acc_clr(fif.acc_clr),
                    .in_west(h_link[i][j]),
                    .in_north(v_link[i][j]),
                    // edge outputs land in column N or row N and go nowhere
                    .out_east(h_link[i][j+1]),
                    .out_south(v_link[i+1][j]),
                    .result(results[i][j])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- pe_array/saturate.sv
// rescales a wide signed sum to a narrower fixed-point format
// arithmetic right shift (floor) followed by clamping to the output range
`timescale 1ns/100ps
`default_nettype none

module saturate #(
    parameter int IN_WIDTH = 2*sa_pkg::DEF_WIDTH + sa_pkg::ACC_GUARD,
    parameter int OUT_WIDTH = sa_pkg::DEF_WIDTH,
    parameter int FRAC_IN = 2*sa_pkg::DEF_FRAC,
    parameter int FRAC_OUT = sa_pkg::DEF_FRAC
) (
    input  logic signed [IN_WIDTH-1:0] in,
    output logic signed [OUT_WIDTH-1:0] out
);

    localparam int SHIFT = FRAC_IN - FRAC_OUT;

    logic signed [IN_WIDTH-1:0] shifted;
    // sign bit of the output plus every bit above it
    logic [IN_WIDTH-OUT_WIDTH:0] top;
    logic fits;

    // >>> on a signed operand rounds toward minus infinity
    assign shifted = in >>> SHIFT;
    assign top = shifted[IN_WIDTH-1:OUT_WIDTH-1];
    // value fits when all top bits agree with the sign
    assign fits = (&top) | ~(|top);

    always_comb begin
        if (fits) begin
            out = shifted[OUT_WIDTH-1:0];
        end else if (shifted[IN_WIDTH-1]) begin
            // most negative value
            out = {1'b1, {(OUT_WIDTH-1){1'b0}}};
        end else begin
            // most positive value
            out = {1'b0, {(OUT_WIDTH-1){1'b1}}};
        end
    end

endmodule

`default_nettype wire

//--- src/operand_feeder.sv
// operand store for A and B, written element by element by the host
// issues skewed row and column vectors into the array, one step per cycle
`timescale 1ns/100ps
`default_nettype none

module operand_feeder #(
    parameter int N = sa_pkg::DEF_N,
    parameter int WIDTH = sa_pkg::DEF_WIDTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic wr_en,
    input  sa_pkg::mat_sel_t wr_sel,
    input  logic [$clog2(N)-1:0] wr_row,
    input  logic [$clog2(N)-1:0] wr_col,
    input  logic [WIDTH-1:0] wr_data,
    feed_if.feeder fif,
    output logic [N-1:0][WIDTH-1:0] west_data,
    output logic [N-1:0][WIDTH-1:0] north_data
);

    import sa_pkg::*;

    // operand register files, row-major
    logic [WIDTH-1:0] mat_a [N][N];
    logic [WIDTH-1:0] mat_b [N][N];

    logic [N-1:0][WIDTH-1:0] west_nxt;
    logic [N-1:0][WIDTH-1:0] north_nxt;

    // host writes, no reset on the storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_sel == MAT_A) begin
                mat_a[wr_row][wr_col] <= wr_data;
            end else begin
                mat_b[wr_row][wr_col] <= wr_data;
            end
        end
    end

    // diagonal pick: row i gets A[i][s-i], column j gets B[s-j][j]
    always_comb begin
        int k;
        west_nxt = '0;
        north_nxt = '0;
        for (int i = 0; i < N; i++) begin
            k = int'(fif.step) - i;
            // zero outside the band or when not feeding
            if (fif.feed_en && (k >= 0) && (k < N)) begin
                west_nxt[i] = mat_a[i][k];
                north_nxt[i] = mat_b[k][i];
            end
        end
    end

    // one register from step to the array edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            west_data <= '0;
            north_data <= '0;
        end else begin
            west_data <= west_nxt;
            north_data <= north_nxt;
        end
    end

endmodule

`default_nettype wire

//--- src/result_drain.sv
// holding bank for the product matrix, loaded on capture
// lets the next job clear the PEs while the host still reads results
`timescale 1ns/100ps
`default_nettype none

module result_drain #(
    parameter int N = sa_pkg::DEF_N,
    parameter int WIDTH = sa_pkg::DEF_WIDTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic [N-1:0][N-1:0][WIDTH-1:0] results,
    input  logic [$clog2(N)-1:0] rd_row,
    input  logic [$clog2(N)-1:0] rd_col,
    feed_if.drain fif,
    output logic [WIDTH-1:0] rd_data
);

    logic [N-1:0][N-1:0][WIDTH-1:0] bank;

    // zeros after reset so early reads are defined
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank <= '0;
        end else if (fif.capture) begin
            bank <= results;
        end
    end

    // read mux, addresses past N-1 read as zero
    always_comb begin
        rd_data = '0;
        if ((int'(rd_row) < N) && (int'(rd_col) < N)) begin
            rd_data = bank[rd_row][rd_col];
        end
    end

endmodule

`default_nettype wire

//--- src/sa_ctrl.sv
// job sequencer: clear, feed, flush and capture after a start pulse
// start is only taken while idle, done pulses once per job
`timescale 1ns/100ps
`default_nettype none

module sa_ctrl #(
    parameter int N = sa_pkg::DEF_N
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic busy,
    output logic done,
    feed_if.ctrl fif
);

    localparam int STEP_W = $clog2(3*N-2);
    // last feed step, 3N-2 feed cycles in total
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(3*N-3);
    // two flush cycles let the far corner PE settle
    localparam logic [STEP_W-1:0] LAST_FLUSH = STEP_W'(1);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_CLEAR = 3'd1;
    localparam logic [2:0] ST_FEED = 3'd2;
    localparam logic [2:0] ST_FLUSH = 3'd3;
    localparam logic [2:0] ST_CAPTURE = 3'd4;

    logic [2:0] state;
    // shared between feed steps and flush count
    logic [STEP_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    state <= ST_FEED;
                    cnt <= '0;
                end
                ST_FEED: begin
                    if (cnt == LAST_STEP) begin
                        state <= ST_FLUSH;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_FLUSH: begin
                    if (cnt == LAST_FLUSH) begin
                        state <= ST_CAPTURE;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_CAPTURE: begin
                    // done lines up with busy falling
                    state <= ST_IDLE;
                    done <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // phase decodes straight off the state register
    assign busy = (state != ST_IDLE);
    assign fif.acc_clr = (state == ST_CLEAR);
    assign fif.feed_en = (state == ST_FEED);
    assign fif.capture = (state == ST_CAPTURE);
    assign fif.step = cnt;

endmodule

`default_nettype wire

//--- src/sa_top.sv
// systolic matrix multiplier top level with plain host ports
// write A and B, pulse start, wait for done, then read C by address
`timescale 1ns/100ps
`default_nettype none

module sa_top #(
    parameter int N = sa_pkg::DEF_N,
    parameter int WIDTH = sa_pkg::DEF_WIDTH,
    parameter int FRAC = sa_pkg::DEF_FRAC
) (
    input  logic clk,
    input  logic rst_n,
    // operand write port
    input  logic wr_en,
    input  sa_pkg::mat_sel_t wr_sel,
    input  logic [$clog2(N)-1:0] wr_row,
    input  logic [$clog2(N)-1:0] wr_col,
    input  logic [WIDTH-1:0] wr_data,
    // job control
    input  logic start,
    output logic busy,
    output logic done,
    // result read port, combinational
    input  logic [$clog2(N)-1:0] rd_row,
    input  logic [$clog2(N)-1:0] rd_col,
    output logic [WIDTH-1:0] rd_data
);

    logic [N-1:0][WIDTH-1:0] west_data;
    logic [N-1:0][WIDTH-1:0] north_data;
    logic [N-1:0][N-1:0][WIDTH-1:0] results;

    // phase controls shared by all datapath blocks
    feed_if #(.N(N)) fif0 ();

    sa_ctrl #(
        .N(N)
    ) u_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .busy(busy),
        .done(done),
        .fif(fif0.ctrl)
    );

    operand_feeder #(
        .N(N),
        .WIDTH(WIDTH)
    ) u_feeder (
        .clk(clk),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .wr_sel(wr_sel),
        .wr_row(wr_row),
        .wr_col(wr_col),
        .wr_data(wr_data),
        .fif(fif0.feeder),
        .west_data(west_data),
        .north_data(north_data)
    );

    pe_array #(
        .N(N),
        .WIDTH(WIDTH),
        .FRAC(FRAC)
    ) u_array (
        .clk(clk),
        .rst_n(rst_n),
        .west_data(west_data),
        .north_data(north_data),
        .fif(fif0.array),
        .results(results)
    );

    result_drain #(
        .N(N),
        .WIDTH(WIDTH)
    ) u_drain (
        .clk(clk),
        .rst_n(rst_n),
        .results(results),
        .rd_row(rd_row),
        .rd_col(rd_col),
        .fif(fif0.drain),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

//--- tests/sa_chk.sv
// controller checks, bound into sa_ctrl
// a failing property bumps fail_count, which the testbench watches
`timescale 1ns/100ps
`default_nettype none

module sa_chk (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic acc_clr,
    input logic feed_en,
    input logic capture
);

    int fail_count = 0;

    // done is a single-cycle strobe
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // feeding and capture are separate phases
    feed_capture_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(feed_en && capture))
        else begin
            $error("feed_en and capture high in the same cycle");
            fail_count++;
        end

    // clear is the one cycle right before the first feed step
    clear_then_feed: assert property (@(posedge clk) disable iff (!rst_n) acc_clr |=> feed_en)
        else begin
            $error("acc_clr not followed by feed_en");
            fail_count++;
        end

    // sync reset, so busy is low from the edge after reset is seen
    busy_low_in_reset: assert property (@(posedge clk) !rst_n |=> !busy)
        else begin
            $error("busy high during reset");
            fail_count++;
        end

endmodule

bind sa_ctrl sa_chk chk0 (
    .clk(clk),
    .rst_n(rst_n),
    .busy(busy),
    .done(done),
    .acc_clr(fif.acc_clr),
    .feed_en(fif.feed_en),
    .capture(fif.capture)
);

`default_nettype wire

//--- tests/sa_tb.sv
// testbench for the systolic multiplier that replays tests/sa_trace.txt
// W, S and R lines drive and check directly and X lines run random jobs against a local model
`timescale 1ns/100ps
`default_nettype none

module sa_tb;

    import sa_pkg::*;

    localparam int N = 3;
    localparam int WIDTH = 16;
    localparam int FRAC = 8;
    localparam int AW = $clog2(N);
    localparam int RST_CYCLES = 16;
    localparam int MAX_VAL = 2**(WIDTH-1) - 1;
    localparam int MIN_VAL = -(2**(WIDTH-1));

    logic clk = 1'b0;
    logic rst_n;
    logic wr_en;
    mat_sel_t wr_sel;
    logic [AW-1:0] wr_row;
    logic [AW-1:0] wr_col;
    logic [WIDTH-1:0] wr_data;
    logic start;
    logic busy;
    logic done;
    logic [AW-1:0] rd_row;
    logic [AW-1:0] rd_col;
    logic [WIDTH-1:0] rd_data;

    // mirror of the operand matrices for the reference model
    int a_mdl [N][N];
    int b_mdl [N][N];
    logic [31:0] rng_state = 32'h627d;
    int cycles = 0;
    // 0 until the trace has been sized
    int limit = 0;

    sa_top #(
        .N(N),
        .WIDTH(WIDTH),
        .FRAC(FRAC)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .wr_sel(wr_sel),
        .wr_row(wr_row),
        .wr_col(wr_col),
        .wr_data(wr_data),
        .start(start),
        .busy(busy),
        .done(done),
        .rd_row(rd_row),
        .rd_col(rd_col),
        .rd_data(rd_data)
    );

    always #2 clk = ~clk;

    // cycle budget and controller assertion watch
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (dut0.u_ctrl.chk0.fail_count != 0) begin
            $display("Error at %0t: controller assertion failed", $time);
            $display("Verification failed");
            $fatal(1, "stopped on assertion failure");
        end else if ((limit > 0) && (cycles >= limit)) begin
            $display("Error at %0t: timeout, done never arrived in %0d cycles", $time, limit);
            $display("Verification failed");
            $fatal(1, "stopped on timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped on first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // clamped running sum of floor(a*b / 2^FRAC) over ascending k
    function automatic int model_elem(input int i, input int j);
        int acc;
        int term;
        acc = 0;
        for (int k = 0; k < N; k++) begin
            term = (a_mdl[i][k] * b_mdl[k][j]) >>> FRAC;
            acc = acc + term;
            if (acc > MAX_VAL) begin
                acc = MAX_VAL;
            end else if (acc < MIN_VAL) begin
                acc = MIN_VAL;
            end
        end
        return acc;
    endfunction

    task automatic write_elem(input mat_sel_t sel, input int row, input int col, input int data);
        @(negedge clk);
        wr_en = 1'b1;
        wr_sel = sel;
        wr_row = AW'(row);
        wr_col = AW'(col);
        wr_data = WIDTH'(data);
        if (sel == MAT_A) begin
            a_mdl[row][col] = data;
        end else begin
            b_mdl[row][col] = data;
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // start a job, optionally pulse start again mid-job, then wait for done
    task automatic run_job(input int extra);
        int lat;
        @(negedge clk);
        start = 1'b1;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            start = (extra > 0) && (lat == 4);
            if (start) begin
                assert (busy) else report_error("busy low while the extra start was driven");
            end
        end while (!done);
        start = 1'b0;
        assert (lat == 3*N+3)
            else report_error($sformatf("done after %0d cycles, expected %0d", lat, 3*N+3));
        assert (!busy) else report_error("busy still high when done pulsed");
        // a second done would mean the extra start was taken
        repeat (3*N+6) begin
            @(negedge clk);
            assert (!done && !busy) else report_error("done or busy seen after the job ended");
        end
    endtask

    task automatic read_check(input int row, input int col, input int exp);
        logic signed [WIDTH-1:0] got;
        @(negedge clk);
        rd_row = AW'(row);
        rd_col = AW'(col);
        @(negedge clk);
        got = rd_data;
        assert (got == exp)
            else report_error($sformatf("C[%0d][%0d] is %0d, expected %0d", row, col, got, exp));
    endtask

    // operands in -8.0 .. +8.0 so some sums clip and most do not
    task automatic random_job();
        int v;
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    rng_state = xorshift(rng_state);
                    v = int'($signed(rng_state[11:0]));
                    write_elem((m == 0) ? MAT_A : MAT_B, i, j, v);
                end
            end
        end
        run_job(0);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                read_check(i, j, model_elem(i, j));
            end
        end
    endtask

    initial begin
        int fd;
        int code;
        int lines;
        int jobs;
        int rnd_jobs;
        int f1;
        int f2;
        int f3;
        int f4;
        byte op;
        string line;
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_sel = MAT_A;
        wr_row = '0;
        wr_col = '0;
        wr_data = '0;
        start = 1'b0;
        rd_row = '0;
        rd_col = '0;

        // first pass only sizes the timeout
        fd = $fopen("tests/sa_trace.txt", "r");
        if (fd == 0) begin
            $display("Error at %0t: cannot open the trace file", $time);
            $display("Verification failed");
            $fatal(1, "no trace");
        end
        lines = 0;
        jobs = 0;
        rnd_jobs = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) begin
                lines++;
                op = line.getc(0);
                if ((op == "S") || (op == "X")) begin
                    jobs++;
                end
                if (op == "X") begin
                    rnd_jobs++;
                end
            end
        end
        $fclose(fd);
        // an X line stands for 2N^2 writes and N^2 reads
        limit = RST_CYCLES + 4*N*N + 40*jobs + 4*(lines + 3*N*N*rnd_jobs);

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // idle with an all-zero bank after reset
        @(negedge clk);
        assert (!busy && !done) else report_error("busy or done high after reset");
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                read_check(i, j, 0);
            end
        end

        fd = $fopen("tests/sa_trace.txt", "r");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) begin
                op = line.getc(0);
                f1 = 0;
                f2 = 0;
                f3 = 0;
                f4 = 0;
                code = $sscanf(line.substr(1, line.len()-1), "%d %d %d %d", f1, f2, f3, f4);
                case (op)
                    "W": write_elem((f1 != 0) ? MAT_B : MAT_A, f2, f3, f4);
                    "S": run_job(f1);
                    "R": read_check(f1, f2, f3);
                    "X": random_job();
                    // comments and blank lines
                    default: ;
                endcase
            end
        end
        $fclose(fd);

        if (dut0.u_ctrl.chk0.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- tests/sa_trace.txt
# W sel(0=A 1=B) row col data | S extra_starts | R row col expected | X random job
# data and expected values are signed decimal, 8 fraction bits
# identity A, so C equals B
W 0 0 0 256
W 0 0 1 0
W 0 0 2 0
W 0 1 0 0
W 0 1 1 256
W 0 1 2 0
W 0 2 0 0
W 0 2 1 0
W 0 2 2 256
W 1 0 0 256
W 1 0 1 -128
W 1 0 2 77
W 1 1 0 -3
W 1 1 1 1000
W 1 1 2 32767
W 1 2 0 5
W 1 2 1 -32768
W 1 2 2 -640
S 0
R 0 0 256
R 0 1 -128
R 0 2 77
R 1 0 -3
R 1 1 1000
R 1 2 32767
R 2 0 5
R 2 1 -32768
R 2 2 -640
# mixed-sign fractions on row 0, floor truncation per term
W 0 0 0 -384
W 0 0 1 3
W 0 0 2 171
S 0
R 0 0 -382
R 0 1 -21685
R 0 2 -161
# large operands on rows 1 and 2, clamp per step then pull back
W 0 1 0 -32768
W 0 1 1 8192
W 0 1 2 51
W 0 2 0 32767
W 0 2 1 32767
W 0 2 2 0
S 0
R 1 0 -32768
R 1 1 26239
R 1 2 32639
R 2 0 32383
R 2 1 32767
R 2 2 32767
# new B column 0, job with a start pulse while busy
W 1 0 0 512
W 1 1 0 0
W 1 2 0 0
S 1
R 0 0 -768
R 1 0 -32768
R 2 0 32767
R 0 1 -21685
# random jobs checked against the model
X
X
